// ==== lookup_params.svh ====
`ifndef LOOKUP_PARAMS_SVH
`define LOOKUP_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Data path widths
// ~~~~~~~~~~~~~~~~~~~~
`define LOOKUP_WORD_BITS 32      // One oop or one memory data word
`define LOOKUP_ADDR_BITS 16      // Word address bits carried on paddr

// ~~~~~~~~~~~~~~~~~~~~
// Method cache
// ~~~~~~~~~~~~~~~~~~~~
`define LOOKUP_CACHE_ENTRIES 16  // Must be a power of two

`endif

// ==== oop_pkg.sv ====
`include "lookup_params.svh"

package oop_pkg;

	// An object pointer is a plain word address into object memory
	typedef logic [`LOOKUP_WORD_BITS-1:0] oop_t;

	localparam oop_t NIL_OOP = '0;  // The nil object

	// ~~~~~~~~~~~~~~~~~~~~
	// Field offsets in words from the object's oop
	// ~~~~~~~~~~~~~~~~~~~~
	localparam oop_t CLASS_SUPERCLASS  = 1;  // Class to search next
	localparam oop_t CLASS_METHOD_DICT = 2;  // Dictionary of this class
	localparam oop_t DICT_SLOT_COUNT   = 1;  // Number of method slots
	localparam oop_t DICT_FIRST_SLOT   = 2;  // Slots follow the count
	localparam oop_t METHOD_SELECTOR   = 5;  // Selector held by a compiled method

endpackage

// ==== lookup_pkg.sv ====
package lookup_pkg;

	// How a lookup ended
	typedef enum logic [1:0] {
		FOUND,
		MISSING,
		BUS_ERROR
	} lookup_status_e;

	// ~~~~~~~~~~~~~~~~~~~~
	// Hierarchy walker FSM
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		IDLE,           // Waiting for an item from the cache stage
		READ_DICT,      // Fetch the method dictionary of the current class
		READ_COUNT,     // Fetch the number of slots in that dictionary
		READ_SLOT,      // Fetch the method oop of one slot
		READ_SELECTOR,  // Fetch the selector of that method
		READ_SUPER,     // Fetch the superclass after a fruitless scan
		EMIT            // Hand the walk result to the result register
	} walker_state_e;

endpackage

// ==== lookup_if.sv ====
interface lookup_if;
	logic valid;
	logic ready;
	oop_pkg::oop_t class_oop;
	oop_pkg::oop_t selector;
	logic hit;             // Cache already knows the method
	oop_pkg::oop_t method; // Meaningful only when hit is set

	modport source (output valid, class_oop, selector, hit, method, input ready);
	modport sink (input valid, class_oop, selector, hit, method, output ready);
endinterface

// Walker results written back into the method cache
interface cache_fill_if;
	logic fill;
	oop_pkg::oop_t class_oop;
	oop_pkg::oop_t selector;
	oop_pkg::oop_t method;

	modport filler (output fill, class_oop, selector, method);
	modport store (input fill, class_oop, selector, method);
endinterface

// ==== mem_rd_if.sv ====
interface mem_rd_if;
	logic req;             // Held with addr until ack
	oop_pkg::oop_t addr;   // Word address
	logic ack;             // One cycle pulse with rdata and err
	oop_pkg::oop_t rdata;
	logic err;

	modport requester (
		output req,
		output addr,
		input ack,
		input rdata,
		input err
	);

	modport responder (
		input req,
		input addr,
		output ack,
		output rdata,
		output err
	);
endinterface

// ==== apb_read_master.sv ====
`include "lookup_params.svh"

module apb_read_master (
	input logic mclk,
	input logic reset,
	mem_rd_if.responder mem,
	output logic psel,
	output logic penable,
	output logic [`LOOKUP_ADDR_BITS-1:0] paddr,
	input logic [`LOOKUP_WORD_BITS-1:0] prdata,
	input logic pready,
	input logic pslverr
);
	typedef enum logic [1:0] {
		AP_IDLE,
		AP_SETUP,
		AP_ACCESS
	} apb_state_e;

	apb_state_e state;
	logic start;
	logic done;

	assign start = (state == AP_IDLE) && mem.req && !mem.ack;  // Req is still high during ack
	assign done = (state == AP_ACCESS) && pready;

	always_ff @(posedge mclk) begin
		if (reset) begin
			state <= AP_IDLE;
			psel <= 1'b0;
			penable <= 1'b0;
			mem.ack <= 1'b0;
		end else begin
			mem.ack <= done;
			case (state)
				AP_IDLE: if (start) begin
					psel <= 1'b1;
					state <= AP_SETUP;
				end
				AP_SETUP: begin
					penable <= 1'b1;  // Setup phase lasts exactly one cycle
					state <= AP_ACCESS;
				end
				AP_ACCESS: if (pready) begin
					psel <= 1'b0;
					penable <= 1'b0;
					state <= AP_IDLE;
				end
				default: state <= AP_IDLE;
			endcase
		end
	end

	always_ff @(posedge mclk) begin
		if (start)
			paddr <= mem.addr[`LOOKUP_ADDR_BITS-1:0];  // Upper oop bits are not decoded
		if (done) begin
			mem.rdata <= prdata;
			mem.err <= pslverr;
		end
	end

	a_penable_in_psel: assert property (@(posedge mclk) disable iff (reset)
		penable |-> psel);

endmodule

// ==== method_cache.sv ====
`include "lookup_params.svh"

module method_cache (
	input logic mclk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input oop_pkg::oop_t req_class,
	input oop_pkg::oop_t req_selector,
	lookup_if.source down,
	cache_fill_if.store fill
);
	import oop_pkg::*;

	localparam int IDX_BITS = $clog2(`LOOKUP_CACHE_ENTRIES);

	logic [`LOOKUP_CACHE_ENTRIES-1:0] entry_valid;
	oop_t tag_class [`LOOKUP_CACHE_ENTRIES];
	oop_t tag_selector [`LOOKUP_CACHE_ENTRIES];
	oop_t entry_method [`LOOKUP_CACHE_ENTRIES];

	logic [IDX_BITS-1:0] req_idx;
	logic [IDX_BITS-1:0] fill_idx;
	logic accept_en;  // Keeps requests out until the first cycle after reset
	logic accept;
	logic req_hit;

	// Last item handed to the walker, which is the one any fill belongs to
	oop_t sent_class;
	oop_t sent_selector;
	logic sent_hit;

	function automatic logic [IDX_BITS-1:0] index_of(oop_t cls, oop_t sel);
		oop_t mix;
		mix = cls ^ sel;
		return mix[IDX_BITS-1:0];
	endfunction

	assign req_idx = index_of(req_class, req_selector);
	assign fill_idx = index_of(fill.class_oop, fill.selector);

	assign req_hit = entry_valid[req_idx] && (tag_class[req_idx] == req_class) &&
		(tag_selector[req_idx] == req_selector);

	assign req_ready = accept_en && (!down.valid || down.ready);
	assign accept = req_valid && req_ready;

	always_ff @(posedge mclk) begin
		if (reset) begin
			accept_en <= 1'b0;
			down.valid <= 1'b0;
			entry_valid <= '0;
		end else begin
			accept_en <= 1'b1;
			if (accept)
				down.valid <= 1'b1;
			else if (down.ready)
				down.valid <= 1'b0;
			if (fill.fill)
				entry_valid[fill_idx] <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage register and entry storage
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mclk) begin
		if (accept) begin
			down.class_oop <= req_class;
			down.selector <= req_selector;
			down.hit <= req_hit;  // Lookup sees entries as they were before a same-cycle fill
			down.method <= entry_method[req_idx];
		end
		if (fill.fill) begin
			tag_class[fill_idx] <= fill.class_oop;
			tag_selector[fill_idx] <= fill.selector;
			entry_method[fill_idx] <= fill.method;
		end
		if (down.valid && down.ready) begin
			sent_class <= down.class_oop;
			sent_selector <= down.selector;
			sent_hit <= down.hit;
		end
	end

	a_fill_after_miss: assert property (@(posedge mclk) disable iff (reset)
		fill.fill |-> !sent_hit && (fill.class_oop == sent_class) &&
			(fill.selector == sent_selector));

endmodule

// ==== hierarchy_walker.sv ====
module hierarchy_walker (
	input logic mclk,
	input logic reset,
	lookup_if.sink up,
	cache_fill_if.filler fill,
	mem_rd_if.requester mem,
	output logic res_valid,
	input logic res_ready,
	output oop_pkg::oop_t res_method,
	output lookup_pkg::lookup_status_e res_status
);
	import oop_pkg::*;
	import lookup_pkg::*;

	walker_state_e state;
	oop_t req_class;   // Receiver class as requested, the tag for the fill
	oop_t cur_class;   // Class whose dictionary is being scanned
	oop_t selector;
	oop_t slot_addr;   // Address of the slot under test
	oop_t slots_left;  // Slots still to test, including the current one
	oop_t candidate;   // Method oop read from the current slot
	oop_t walk_method;
	lookup_status_e walk_status;
	logic res_free;
	logic reading;

	assign res_free = !res_valid || res_ready;
	assign up.ready = (state == IDLE) && res_free;
	assign reading = (state != IDLE) && (state != EMIT);

	always_ff @(posedge mclk) begin
		if (reset) begin
			state <= IDLE;
			mem.req <= 1'b0;
			res_valid <= 1'b0;
			fill.fill <= 1'b0;
		end else begin
			fill.fill <= 1'b0;
			mem.req <= reading && !mem.ack;  // Drops for one cycle after every ack
			if (res_ready)
				res_valid <= 1'b0;
			case (state)
				IDLE: if (up.valid && up.ready) begin
					if (up.hit) begin
						res_valid <= 1'b1;
						res_method <= up.method;
						res_status <= FOUND;
					end else begin
						req_class <= up.class_oop;
						cur_class <= up.class_oop;
						selector <= up.selector;
						mem.addr <= up.class_oop + CLASS_METHOD_DICT;
						state <= READ_DICT;
					end
				end
				READ_DICT: if (mem.ack) begin
					slot_addr <= mem.rdata + DICT_FIRST_SLOT;
					mem.addr <= mem.rdata + DICT_SLOT_COUNT;
					state <= READ_COUNT;
				end
				READ_COUNT: if (mem.ack) begin
					slots_left <= mem.rdata;
					if (mem.rdata == '0) begin
						mem.addr <= cur_class + CLASS_SUPERCLASS;  // Empty dictionary
						state <= READ_SUPER;
					end else begin
						mem.addr <= slot_addr;
						state <= READ_SLOT;
					end
				end
				READ_SLOT: if (mem.ack) begin
					candidate <= mem.rdata;
					mem.addr <= mem.rdata + METHOD_SELECTOR;
					state <= READ_SELECTOR;
				end
				READ_SELECTOR: if (mem.ack) begin
					if (mem.rdata == selector) begin
						walk_method <= candidate;
						walk_status <= FOUND;
						fill.fill <= 1'b1;
						fill.class_oop <= req_class;
						fill.selector <= selector;
						fill.method <= candidate;
						state <= EMIT;
					end else if (slots_left == oop_t'(1)) begin
						mem.addr <= cur_class + CLASS_SUPERCLASS;
						state <= READ_SUPER;
					end else begin
						slots_left <= slots_left - oop_t'(1);
						slot_addr <= slot_addr + oop_t'(1);
						mem.addr <= slot_addr + oop_t'(1);
						state <= READ_SLOT;
					end
				end
				READ_SUPER: if (mem.ack) begin
					if (mem.rdata == NIL_OOP) begin
						walk_method <= NIL_OOP;  // Top of the chain reached
						walk_status <= MISSING;
						state <= EMIT;
					end else begin
						cur_class <= mem.rdata;
						mem.addr <= mem.rdata + CLASS_METHOD_DICT;
						state <= READ_DICT;
					end
				end
				EMIT: if (res_free) begin
					res_valid <= 1'b1;
					res_method <= walk_method;
					res_status <= walk_status;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
			// A slave error ends the walk whatever the read was for
			if (reading && mem.ack && mem.err) begin
				walk_method <= NIL_OOP;
				walk_status <= BUS_ERROR;
				fill.fill <= 1'b0;
				state <= EMIT;
			end
		end
	end

	a_addr_stable: assert property (@(posedge mclk) disable iff (reset)
		mem.req && !mem.ack |=> $stable(mem.addr));

endmodule

// ==== method_lookup_top.sv ====
`include "lookup_params.svh"

module method_lookup_top (
	input logic mclk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input oop_pkg::oop_t req_class,
	input oop_pkg::oop_t req_selector,
	output logic res_valid,
	input logic res_ready,
	output oop_pkg::oop_t res_method,
	output lookup_pkg::lookup_status_e res_status,
	output logic psel,
	output logic penable,
	output logic [`LOOKUP_ADDR_BITS-1:0] paddr,
	input logic [`LOOKUP_WORD_BITS-1:0] prdata,
	input logic pready,
	input logic pslverr
);
	lookup_if stage_link ();
	cache_fill_if fill_link ();
	mem_rd_if mem_link ();

	method_cache u_cache (
		.mclk(mclk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_class(req_class),
		.req_selector(req_selector),
		.down(stage_link.source),
		.fill(fill_link.store)
	);

	hierarchy_walker u_walker (
		.mclk(mclk),
		.reset(reset),
		.up(stage_link.sink),
		.fill(fill_link.filler),
		.mem(mem_link.requester),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_method(res_method),
		.res_status(res_status)
	);

	apb_read_master u_apb (
		.mclk(mclk),
		.reset(reset),
		.mem(mem_link.responder),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

endmodule

// ==== tb_object_memory.sv ====
`include "lookup_params.svh"

module tb_object_memory (
	input logic mclk,
	input logic psel,
	input logic penable,
	input logic [`LOOKUP_ADDR_BITS-1:0] paddr,
	output logic [`LOOKUP_WORD_BITS-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 4096;

	logic [`LOOKUP_WORD_BITS-1:0] words [MEM_WORDS];
	logic in_range;
	int seed;
	int wait_left;

	assign in_range = int'(paddr) < MEM_WORDS;

	// Background contents, a different value at every word
	initial begin
		for (int a = 0; a < MEM_WORDS; a++)
			words[a] = 32'h5A00_0000 ^ (a * 32'h0001_9E37);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// APB slave responses
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		seed = 24899;
		wait_left = 0;
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;
		forever begin
			@(posedge mclk);
			#1;
			pready = 1'b0;
			pslverr = 1'b0;
			if (psel && !penable) begin
				wait_left = $random(seed) & 3;  // Zero to three wait states
			end else if (psel && penable) begin
				if (wait_left > 0) begin
					wait_left--;
				end else begin
					pready = 1'b1;
					pslverr = !in_range;  // Words past the end of memory answer with an error
					prdata = in_range ? words[paddr[11:0]] : '0;
				end
			end
		end
	end

endmodule

// ==== tb_method_lookup.sv ====
`include "lookup_params.svh"

module tb_method_lookup;
	timeunit 1ns;
	timeprecision 100ps;

	import oop_pkg::*;
	import lookup_pkg::*;

	localparam int MEM_WORDS = 4096;
	localparam int WAIT_LIMIT = 2000;  // Cycles allowed for any one wait
	localparam int BURST_LEN = 60;

	localparam oop_t TOP_CLASS = 'h100;
	localparam oop_t MID_CLASS = 'h110;       // Has an empty dictionary
	localparam oop_t LEAF_CLASS = 'h120;
	localparam oop_t SIDE_CLASS = 'h130;      // Second subclass of the top class
	localparam oop_t BAD_DICT_CLASS = 'h140;  // Dictionary pointer leaves memory
	localparam oop_t FAR_CLASS = 'h2000;      // Class oop outside memory
	localparam oop_t SEL = 'h800;             // Selector n is SEL + n
	localparam oop_t SEL_NONE = 'h8ff;

	logic mclk;
	logic reset;
	logic req_valid;
	logic req_ready;
	oop_t req_class;
	oop_t req_selector;
	logic res_valid;
	logic res_ready;
	oop_t res_method;
	lookup_status_e res_status;
	logic psel;
	logic penable;
	logic [`LOOKUP_ADDR_BITS-1:0] paddr;
	logic [`LOOKUP_WORD_BITS-1:0] prdata;
	logic pready;
	logic pslverr;

	int seed;
	logic random_ready;
	lookup_status_e exp_status_q [$];
	oop_t exp_method_q [$];
	oop_t burst_class [BURST_LEN];
	oop_t burst_selector [BURST_LEN];
	int status_errors = 0;
	int method_errors = 0;
	int other_errors = 0;
	int requests_sent = 0;
	int results_seen = 0;

	method_lookup_top dut (.*);

	tb_object_memory mem_model (.*);

	initial begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;
	end

	task automatic put_word(input oop_t addr, input oop_t value);
		mem_model.words[addr[11:0]] = value;
	endtask

	task automatic make_class(input oop_t cls, input oop_t super_cls, input oop_t dict);
		put_word(cls + CLASS_SUPERCLASS, super_cls);
		put_word(cls + CLASS_METHOD_DICT, dict);
	endtask

	task automatic add_method(input oop_t dict, input int slot, input oop_t meth, input oop_t sel);
		put_word(dict + DICT_FIRST_SLOT + oop_t'(slot), meth);
		put_word(meth + METHOD_SELECTOR, sel);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic logic fetch_word(input oop_t addr, output oop_t data);
		data = '0;
		if (addr >= oop_t'(MEM_WORDS))
			return 1'b0;
		data = mem_model.words[addr[11:0]];
		return 1'b1;
	endfunction

	function automatic void ref_lookup(input oop_t cls, input oop_t sel,
		output lookup_status_e status, output oop_t method);
		oop_t cur;
		oop_t dict;
		oop_t count;
		oop_t cand;
		oop_t cand_sel;
		int depth;
		int i;
		status = BUS_ERROR;  // Every early return below is a failed read
		method = '0;
		cur = cls;
		for (depth = 0; depth < 32; depth++) begin
			if (!fetch_word(cur + CLASS_METHOD_DICT, dict))
				return;
			if (!fetch_word(dict + DICT_SLOT_COUNT, count))
				return;
			for (i = 0; i < int'(count); i++) begin
				if (!fetch_word(dict + DICT_FIRST_SLOT + oop_t'(i), cand))
					return;
				if (!fetch_word(cand + METHOD_SELECTOR, cand_sel))
					return;
				if (cand_sel == sel) begin
					status = FOUND;
					method = cand;
					return;
				end
			end
			if (!fetch_word(cur + CLASS_SUPERCLASS, cur))
				return;
			if (cur == '0) begin
				status = MISSING;
				return;
			end
		end
	endfunction

	task automatic print_error_counts();
		$display("Errors: status %0d, method %0d, other %0d", status_errors, method_errors,
			other_errors);
	endtask

	task automatic abort_run(input string why);
		other_errors++;
		$display("Timeout at %0t: %s", $time, why);
		print_error_counts();
		$display("Some tests failed");
		$finish;
	endtask

	// Called a little after a rising edge, and returns at the same point of a later cycle
	task automatic send_request(input oop_t cls, input oop_t sel);
		int waited;
		lookup_status_e status;
		oop_t method;
		ref_lookup(cls, sel, status, method);
		exp_status_q.push_back(status);
		exp_method_q.push_back(method);
		requests_sent++;
		req_valid = 1'b1;
		req_class = cls;
		req_selector = sel;
		waited = 0;
		@(negedge mclk);
		while (!req_ready) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("request was never accepted");
			@(negedge mclk);
		end
		@(posedge mclk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (exp_status_q.size() != 0) begin
			@(posedge mclk);
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("results still outstanding");
		end
		#1;
	endtask

	task automatic run_directed();
		send_request(LEAF_CLASS, SEL + 0);  // Own class
		send_request(LEAF_CLASS, SEL + 5);
		send_request(LEAF_CLASS, SEL + 2);  // Also in the top class but the leaf wins
		send_request(LEAF_CLASS, SEL + 1);  // Through the empty middle dictionary
		send_request(MID_CLASS, SEL + 3);
		send_request(TOP_CLASS, SEL + 0);   // Same cache index as the leaf lookup
		send_request(SIDE_CLASS, SEL + 1);
		send_request(SIDE_CLASS, SEL + 6);
		send_request(SIDE_CLASS, SEL + 2);
		send_request(LEAF_CLASS, SEL + 6);  // Only defined in a sibling
		send_request(LEAF_CLASS, SEL_NONE);
		send_request(TOP_CLASS, SEL + 7);
		send_request(FAR_CLASS, SEL + 0);
		send_request(BAD_DICT_CLASS, SEL + 0);
	endtask

	initial begin : drive_res_ready
		res_ready = 1'b0;
		forever begin
			@(posedge mclk);
			#1;
			if (random_ready)
				res_ready = ($random(seed) & 1) == 1;
			else
				res_ready = 1'b1;
		end
	end

	initial begin : compare_results
		lookup_status_e exp_status;
		oop_t exp_method;
		forever begin
			@(negedge mclk);
			if (!reset && res_valid && res_ready) begin
				results_seen++;
				if (exp_status_q.size() == 0) begin
					other_errors++;
					$display("Result at %0t arrived with no request outstanding", $time);
				end else begin
					exp_status = exp_status_q.pop_front();
					exp_method = exp_method_q.pop_front();
					if (res_status != exp_status) begin
						status_errors++;
						$display("MISMATCH at %0t: res_status got %s expected %s", $time,
							res_status.name(), exp_status.name());
					end
					if (res_method != exp_method) begin
						method_errors++;
						$display("MISMATCH at %0t: res_method got %h expected %h", $time,
							res_method, exp_method);
					end
				end
			end
		end
	end

	initial begin : run_tests
		int i;
		reset = 1'b1;
		req_valid = 1'b0;
		req_class = '0;
		req_selector = '0;
		random_ready = 1'b0;
		seed = 24899;
		@(posedge mclk);
		#1;
		make_class(TOP_CLASS, '0, 'h400);
		make_class(MID_CLASS, TOP_CLASS, 'h420);
		make_class(LEAF_CLASS, MID_CLASS, 'h440);
		make_class(SIDE_CLASS, TOP_CLASS, 'h460);
		make_class(BAD_DICT_CLASS, TOP_CLASS, 'h3000);
		put_word('h401, 5);
		put_word('h421, 0);
		put_word('h441, 3);
		put_word('h461, 2);
		for (i = 0; i < 5; i++)
			add_method('h400, i, 'h200 + oop_t'(8 * i), SEL + oop_t'(i));
		add_method('h440, 0, 'h228, SEL + 0);
		add_method('h440, 1, 'h230, SEL + 5);
		add_method('h440, 2, 'h238, SEL + 2);
		add_method('h460, 0, 'h240, SEL + 6);
		add_method('h460, 1, 'h248, SEL + 1);
		for (i = 0; i < BURST_LEN; i++) begin
			case ($random(seed) & 7)
				0: burst_class[i] = TOP_CLASS;
				1: burst_class[i] = MID_CLASS;
				2: burst_class[i] = SIDE_CLASS;
				3: burst_class[i] = BAD_DICT_CLASS;
				4: burst_class[i] = FAR_CLASS;
				default: burst_class[i] = LEAF_CLASS;
			endcase
			burst_selector[i] = SEL + oop_t'($random(seed) & 7);
		end
		repeat (3) @(posedge mclk);
		#1;
		reset = 1'b0;

		run_directed();
		wait_for_results();
		run_directed();  // Found lookups now come from the cache
		wait_for_results();

		@(negedge mclk);
		random_ready = 1'b1;
		@(posedge mclk);
		#1;
		for (i = 0; i < BURST_LEN; i++)
			send_request(burst_class[i], burst_selector[i]);
		wait_for_results();
		random_ready = 1'b0;
		repeat (20) @(posedge mclk);  // Any duplicated result shows up here
		if (results_seen != requests_sent) begin
			other_errors++;
			$display("Sent %0d requests but saw %0d results", requests_sent, results_seen);
		end

		print_error_counts();
		if (status_errors + method_errors + other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
oop_pkg.sv
lookup_pkg.sv
lookup_if.sv
mem_rd_if.sv
apb_read_master.sv
method_cache.sv
hierarchy_walker.sv
method_lookup_top.sv
tb_object_memory.sv
tb_method_lookup.sv

// ==== Makefile ====
TOP = tb_method_lookup

obj_dir/V$(TOP): verilog.f lookup_params.svh $(shell grep '\.sv$$' verilog.f)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
